// File: source/cp0_cfg.svh
`ifndef CP0_CFG_SVH
`define CP0_CFG_SVH

// CP0 register numbers, all at select 0
`define CP0_REG_BADVADDR 5'd8
`define CP0_REG_COUNT    5'd9
`define CP0_REG_COMPARE  5'd11
`define CP0_REG_STATUS   5'd12
`define CP0_REG_CAUSE    5'd13
`define CP0_REG_EPC      5'd14
`define CP0_REG_PRID     5'd15
`define CP0_REG_CONFIG   5'd16

// Exception vector bases, BEV picks boot or normal
`define EXC_BASE_RESET   32'hBFC0_0000
`define EXC_BASE_BOOT    32'hBFC0_0200
`define EXC_BASE_NORMAL  32'h8000_0000

`define EXC_OFFSET_GENERAL 32'h0000_0180
`define EXC_OFFSET_SPECIAL 32'h0000_0200 // Interrupts when Cause.IV is set

`define PRID_REVISION     8'd1
`define CONFIG_BIG_ENDIAN 1'b1

`endif

// File: source/cp0RegisterPkg.sv
package cp0RegisterPkg;

    // Full CP0 register contents as seen by Mfc0/Mtc0
    typedef logic [31:0] word_t;

    // Rd field of Mfc0/Mtc0
    typedef logic [4:0] regIndex_t;

    // Bit 7 timer, bits 6..2 hardware lines, bits 1..0 software
    typedef logic [7:0] interruptMask_t;

endpackage

// File: source/exceptionPkg.sv
package exceptionPkg;

    typedef logic [3:0]  excCode_t;   // Low four bits of Cause.ExcCode
    typedef logic [31:0] address_t;   // Program or data address

    // One bit per pipeline stage that can raise an exception
    typedef logic [2:0] stageMask_t;

    localparam int STAGE_ID  = 0;
    localparam int STAGE_EX  = 1;
    localparam int STAGE_MEM = 2;

    localparam excCode_t EXC_INT  = 4'd0;
    localparam excCode_t EXC_ADEL = 4'd4;  // Load or fetch address error
    localparam excCode_t EXC_ADES = 4'd5;  // Store address error
    localparam excCode_t EXC_SYS  = 4'd8;
    localparam excCode_t EXC_BP   = 4'd9;
    localparam excCode_t EXC_RI   = 4'd10;
    localparam excCode_t EXC_CPU  = 4'd11; // Coprocessor unusable
    localparam excCode_t EXC_OV   = 4'd12;
    localparam excCode_t EXC_TR   = 4'd13;

endpackage

// File: source/cp0Interfaces.sv
`timescale 1ns/100ps

// Exception take event and CP0 commits, from decode to the register file
interface exceptionTakeIf;
    logic                   take;            // Exception commits this cycle
    exceptionPkg::excCode_t code;
    exceptionPkg::address_t restartPc;
    logic                   branchDelay;     // Faulting instruction sits in a delay slot
    exceptionPkg::address_t badAddress;
    logic                   badAddressValid; // MEM address error only
    logic                   eretCommit;
    logic                   writeCommit;     // Mtc0 allowed to write

    modport decode (output take, code, restartPc, branchDelay, badAddress,
                    output badAddressValid, eretCommit, writeCommit);
    modport execute (input take, code, restartPc, branchDelay, badAddress,
                     input badAddressValid, eretCommit, writeCommit);
endinterface

// Architectural CP0 state, owned by the register file
interface cp0StateIf;
    logic                           cu0;
    logic                           bev;
    cp0RegisterPkg::interruptMask_t im;
    logic                           um;
    logic                           exl;
    logic                           ie;
    logic                           branchDelay; // Cause.BD
    logic                           iv;
    cp0RegisterPkg::interruptMask_t ip;
    exceptionPkg::excCode_t         code;
    cp0RegisterPkg::word_t          epc;
    cp0RegisterPkg::word_t          badVAddr;
    cp0RegisterPkg::word_t          count;
    cp0RegisterPkg::word_t          compare;
    logic                           kernelMode;

    modport state (output cu0, bev, im, um, exl, ie, branchDelay, iv, ip, code,
                   output epc, badVAddr, count, compare, kernelMode);
    modport view (input cu0, bev, im, um, exl, ie, branchDelay, iv, ip, code,
                  input epc, badVAddr, count, compare, kernelMode);
endinterface

// File: source/exceptionDecode.sv
`timescale 1ns/100ps

module exceptionDecode (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   mfc0,
    input  logic                   mtc0,
    input  logic                   eret,
    input  logic                   ifStall,
    input  logic                   idStall,    // No commits while high
    input  logic                   excAdEL,
    input  logic                   excAdES,
    input  logic                   excOv,
    input  logic                   excTr,
    input  logic                   excSys,
    input  logic                   excBp,
    input  logic                   excRi,
    input  exceptionPkg::address_t idRestartPc,
    input  exceptionPkg::address_t exRestartPc,
    input  exceptionPkg::address_t memRestartPc,
    input  logic                   idIsBd,
    input  logic                   exIsBd,
    input  logic                   memIsBd,
    input  exceptionPkg::address_t badAddrMem,
    input  logic                   idIsFlushed,
    input  logic                   idCanErr,   // Cumulative over ID, EX and MEM
    input  logic                   exCanErr,   // Cumulative over EX and MEM
    input  logic                   memCanErr,
    exceptionTakeIf.decode         take,
    cp0StateIf.view                state,
    output logic                   idExceptionStall,
    output logic                   exExceptionStall,
    output logic                   memExceptionStall,
    output logic                   ifExceptionFlush,
    output logic                   idExceptionFlush,
    output logic                   exExceptionFlush,
    output logic                   memExceptionFlush,
    output logic                   excPcSelect
);
    logic                     kernelAccess;
    logic                     coprocessorUnusable;
    logic                     interruptDetect;
    exceptionPkg::stageMask_t detect;
    exceptionPkg::stageMask_t mask;
    exceptionPkg::stageMask_t ready;
    logic                     resetQ;

    assign kernelAccess        = state.cu0 | state.kernelMode;
    assign coprocessorUnusable = (mfc0 | mtc0 | eret) & ~kernelAccess;

    // Interrupts only enter on a clean pipeline, and never beside an ERET
    assign interruptDetect = state.ie & (|(state.ip & state.im)) & ~state.exl
                           & ~idIsFlushed & ~idCanErr & ~eret;

    assign detect[exceptionPkg::STAGE_MEM] = excAdEL | excAdES | excTr;
    assign detect[exceptionPkg::STAGE_EX]  = excOv;
    assign detect[exceptionPkg::STAGE_ID]  = excSys | excBp | excRi | coprocessorUnusable
                                           | interruptDetect;

    // A stage waits while any later stage may still fault
    assign mask[exceptionPkg::STAGE_MEM] = ifStall;
    assign mask[exceptionPkg::STAGE_EX]  = ifStall | memCanErr;
    assign mask[exceptionPkg::STAGE_ID]  = ifStall | memCanErr | exCanErr;

    assign ready = detect & ~mask & {3{~idStall}}; // Nested masks, oldest detect is ready first

    assign memExceptionStall = detect[exceptionPkg::STAGE_MEM] & mask[exceptionPkg::STAGE_MEM];
    assign exExceptionStall  = detect[exceptionPkg::STAGE_EX] & mask[exceptionPkg::STAGE_EX]
                             & ~detect[exceptionPkg::STAGE_MEM];
    assign idExceptionStall  = (detect[exceptionPkg::STAGE_ID] | eret | mtc0)
                             & mask[exceptionPkg::STAGE_ID]
                             & ~(detect[exceptionPkg::STAGE_EX] | detect[exceptionPkg::STAGE_MEM]);

    // A faulting stage flushes itself and everything behind it
    assign memExceptionFlush = detect[exceptionPkg::STAGE_MEM];
    assign exExceptionFlush  = memExceptionFlush | detect[exceptionPkg::STAGE_EX];
    assign idExceptionFlush  = exExceptionFlush | detect[exceptionPkg::STAGE_ID];
    assign ifExceptionFlush  = idExceptionFlush | take.eretCommit | resetQ;

    // ERET and Mtc0 wait under the ID mask like an ID exception
    assign take.take            = |ready;
    assign take.eretCommit      = eret & kernelAccess & ~idStall
                                & ~mask[exceptionPkg::STAGE_ID];
    assign take.writeCommit     = mtc0 & kernelAccess & ~idStall
                                & ~mask[exceptionPkg::STAGE_ID] & ~idExceptionFlush;
    assign take.badAddress      = badAddrMem;
    assign take.badAddressValid = ready[exceptionPkg::STAGE_MEM] & (excAdEL | excAdES);

    assign excPcSelect = reset | take.eretCommit | take.take;

    // Forward-most stage wins, interrupt last
    always_comb begin
        if (excAdEL)                  take.code = exceptionPkg::EXC_ADEL;
        else if (excAdES)             take.code = exceptionPkg::EXC_ADES;
        else if (excTr)               take.code = exceptionPkg::EXC_TR;
        else if (excOv)               take.code = exceptionPkg::EXC_OV;
        else if (excSys)              take.code = exceptionPkg::EXC_SYS;
        else if (excBp)               take.code = exceptionPkg::EXC_BP;
        else if (excRi)               take.code = exceptionPkg::EXC_RI;
        else if (coprocessorUnusable) take.code = exceptionPkg::EXC_CPU;
        else                          take.code = exceptionPkg::EXC_INT;
    end

    always_comb begin
        if (detect[exceptionPkg::STAGE_MEM]) begin
            take.restartPc   = memRestartPc;
            take.branchDelay = memIsBd;
        end else if (detect[exceptionPkg::STAGE_EX]) begin
            take.restartPc   = exRestartPc;
            take.branchDelay = exIsBd;
        end else begin
            take.restartPc   = idRestartPc;
            take.branchDelay = idIsBd;
        end
    end

    always_ff @(posedge clock) begin
        resetQ <= reset; // IF flush one cycle after reset
    end
endmodule

// File: source/cp0RegisterExecute.sv
`timescale 1ns/100ps
`include "cp0_cfg.svh"

module cp0RegisterExecute (
    input  logic                      clock,
    input  logic                      reset,
    input  cp0RegisterPkg::regIndex_t registerIndex,
    input  cp0RegisterPkg::word_t     writeData,
    input  logic [4:0]                interrupts,  // Hardware lines into IP[6:2]
    exceptionTakeIf.execute           take,
    cp0StateIf.state                  state
);
    logic countWrite;
    logic compareWrite;
    logic statusWrite;
    logic causeWrite;
    logic epcWrite;
    logic timerMatch;

    assign countWrite   = take.writeCommit & (registerIndex == `CP0_REG_COUNT);
    assign compareWrite = take.writeCommit & (registerIndex == `CP0_REG_COMPARE);
    assign statusWrite  = take.writeCommit & (registerIndex == `CP0_REG_STATUS);
    assign causeWrite   = take.writeCommit & (registerIndex == `CP0_REG_CAUSE);
    assign epcWrite     = take.writeCommit & (registerIndex == `CP0_REG_EPC);

    assign timerMatch       = state.count == state.compare;
    assign state.kernelMode = ~state.um | state.exl;

    always_ff @(posedge clock) begin
        if (reset) begin
            state.count       <= '0;
            state.compare     <= '0;
            state.cu0         <= 1'b0;
            state.bev         <= 1'b1;  // Boot vectors until software clears BEV
            state.im          <= '0;
            state.um          <= 1'b0;
            state.exl         <= 1'b0;
            state.ie          <= 1'b0;
            state.branchDelay <= 1'b0;
            state.iv          <= 1'b0;
            state.ip          <= '0;
            state.code        <= exceptionPkg::EXC_INT;
        end else begin
            state.count <= countWrite ? writeData : state.count + 32'd1;
            if (compareWrite) begin
                state.compare <= writeData;
            end
            if (statusWrite) begin
                state.cu0 <= writeData[28];
                state.bev <= writeData[22];
                state.im  <= writeData[15:8];
                state.um  <= writeData[4];
                state.ie  <= writeData[0];
            end
            if (causeWrite) begin
                state.iv      <= writeData[23];
                state.ip[1:0] <= writeData[9:8]; // Software interrupts
            end

            // Timer pending is sticky until Compare is rewritten
            if (compareWrite)
                state.ip[7] <= 1'b0;
            else if (timerMatch)
                state.ip[7] <= 1'b1;
            state.ip[6:2] <= interrupts;

            if (take.take) begin
                state.exl  <= 1'b1;
                state.code <= take.code;
                if (!state.exl)
                    state.branchDelay <= take.branchDelay; // Nested exceptions keep BD
            end else if (statusWrite) begin
                state.exl <= writeData[1];
            end else if (take.eretCommit) begin
                state.exl <= 1'b0;
            end
        end
    end

    // EPC and BadVAddr carry addresses only
    always_ff @(posedge clock) begin
        if (take.take) begin
            if (!state.exl)
                state.epc <= take.restartPc;
        end else if (epcWrite) begin
            state.epc <= writeData;
        end
        if (take.badAddressValid)
            state.badVAddr <= take.badAddress;
    end
endmodule

// File: source/cp0ReadResult.sv
`timescale 1ns/100ps
`include "cp0_cfg.svh"

module cp0ReadResult (
    input  logic                      reset,
    input  logic                      mfc0,
    input  logic                      eret,
    input  logic                      idStall,
    input  cp0RegisterPkg::regIndex_t registerIndex,
    input  exceptionPkg::excCode_t    excCode,      // Prioritized code from decode
    cp0StateIf.view                   state,
    output cp0RegisterPkg::word_t     readData,
    output exceptionPkg::address_t    excPcOut
);
    logic                   kernelAccess;
    cp0RegisterPkg::word_t  statusWord;
    cp0RegisterPkg::word_t  causeWord;
    cp0RegisterPkg::word_t  pridWord;
    cp0RegisterPkg::word_t  configWord;
    exceptionPkg::address_t vectorBase;
    exceptionPkg::address_t vectorOffset;

    assign kernelAccess = state.cu0 | state.kernelMode;

    // Unimplemented fields read as zero
    assign statusWord = {3'b000, state.cu0, 5'b00000, state.bev, 6'b000000, state.im,
                         3'b000, state.um, 2'b00, state.exl, state.ie};
    assign causeWord  = {state.branchDelay, 7'b0000000, state.iv, 7'b0000000, state.ip,
                         2'b00, state.code, 2'b00};
    assign pridWord   = {24'h000000, `PRID_REVISION};
    assign configWord = {1'b1, 15'h0000, `CONFIG_BIG_ENDIAN, 15'h0000}; // M set, BE at bit 15

    always_comb begin
        readData = '0;
        if (mfc0 && kernelAccess) begin
            case (registerIndex)
                `CP0_REG_BADVADDR: readData = state.badVAddr;
                `CP0_REG_COUNT:    readData = state.count;
                `CP0_REG_COMPARE:  readData = state.compare;
                `CP0_REG_STATUS:   readData = statusWord;
                `CP0_REG_CAUSE:    readData = causeWord;
                `CP0_REG_EPC:      readData = state.epc;
                `CP0_REG_PRID:     readData = pridWord;
                `CP0_REG_CONFIG:   readData = configWord;
                default:           readData = '0;
            endcase
        end
    end

    assign vectorBase   = state.bev ? `EXC_BASE_BOOT : `EXC_BASE_NORMAL;
    assign vectorOffset = (excCode == exceptionPkg::EXC_INT && state.iv) ?
                          `EXC_OFFSET_SPECIAL : `EXC_OFFSET_GENERAL;

    always_comb begin
        if (reset)
            excPcOut = `EXC_BASE_RESET;
        else if (eret && kernelAccess && !idStall)
            excPcOut = state.epc;                // Return from exception
        else
            excPcOut = vectorBase + vectorOffset;
    end
endmodule

// File: source/coprocessorZero.sv
`timescale 1ns/100ps

module coprocessorZero (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           mfc0,
    input  logic                           mtc0,
    input  logic                           eret,
    input  logic                           ifStall,
    input  logic                           idStall,
    input  cp0RegisterPkg::regIndex_t      registerIndex,
    input  cp0RegisterPkg::word_t          writeData,
    input  logic [4:0]                     interrupts,
    input  logic                           excAdEL,
    input  logic                           excAdES,
    input  logic                           excOv,
    input  logic                           excTr,
    input  logic                           excSys,
    input  logic                           excBp,
    input  logic                           excRi,
    input  exceptionPkg::address_t         idRestartPc,
    input  exceptionPkg::address_t         exRestartPc,
    input  exceptionPkg::address_t         memRestartPc,
    input  logic                           idIsBd,
    input  logic                           exIsBd,
    input  logic                           memIsBd,
    input  exceptionPkg::address_t         badAddrMem,
    input  logic                           idIsFlushed,
    input  logic                           idCanErr,
    input  logic                           exCanErr,
    input  logic                           memCanErr,
    output cp0RegisterPkg::word_t          readData,
    output logic                           kernelMode,
    output logic                           idExceptionStall,
    output logic                           exExceptionStall,
    output logic                           memExceptionStall,
    output logic                           ifExceptionFlush,
    output logic                           idExceptionFlush,
    output logic                           exExceptionFlush,
    output logic                           memExceptionFlush,
    output logic                           excPcSelect,
    output exceptionPkg::address_t         excPcOut,
    output cp0RegisterPkg::interruptMask_t pendingInterrupts
);
    exceptionTakeIf takeBus ();
    cp0StateIf      stateBus ();

    assign kernelMode        = stateBus.kernelMode;
    assign pendingInterrupts = stateBus.ip;  // Cause.IP for diagnostics

    exceptionDecode u_exceptionDecode (
        .clock(clock), .reset(reset), .mfc0(mfc0), .mtc0(mtc0), .eret(eret),
        .ifStall(ifStall), .idStall(idStall),
        .excAdEL(excAdEL), .excAdES(excAdES), .excOv(excOv), .excTr(excTr),
        .excSys(excSys), .excBp(excBp), .excRi(excRi),
        .idRestartPc(idRestartPc), .exRestartPc(exRestartPc), .memRestartPc(memRestartPc),
        .idIsBd(idIsBd), .exIsBd(exIsBd), .memIsBd(memIsBd),
        .badAddrMem(badAddrMem), .idIsFlushed(idIsFlushed),
        .idCanErr(idCanErr), .exCanErr(exCanErr), .memCanErr(memCanErr),
        .take(takeBus.decode), .state(stateBus.view),
        .idExceptionStall(idExceptionStall), .exExceptionStall(exExceptionStall),
        .memExceptionStall(memExceptionStall), .ifExceptionFlush(ifExceptionFlush),
        .idExceptionFlush(idExceptionFlush), .exExceptionFlush(exExceptionFlush),
        .memExceptionFlush(memExceptionFlush), .excPcSelect(excPcSelect)
    );

    cp0RegisterExecute u_cp0RegisterExecute (
        .clock(clock), .reset(reset), .registerIndex(registerIndex),
        .writeData(writeData), .interrupts(interrupts),
        .take(takeBus.execute), .state(stateBus.state)
    );

    // Vector choice follows the code decode has prioritized
    // EPC is only returned for an ERET that decode lets commit
    cp0ReadResult u_cp0ReadResult (
        .reset(reset), .mfc0(mfc0), .eret(takeBus.eretCommit), .idStall(idStall),
        .registerIndex(registerIndex), .excCode(takeBus.code), .state(stateBus.view),
        .readData(readData), .excPcOut(excPcOut)
    );
endmodule

// File: testbench/coprocessorZero_properties.sv
`timescale 1ns/100ps

module coprocessorZero_properties (
    input logic clock,
    input logic reset,
    input logic idExceptionStall,
    input logic exExceptionStall,
    input logic memExceptionStall,
    input logic kernelMode,
    input logic takeNow,   // Exception commit from decode
    input logic eretNow    // ERET commit from decode
);
    // No stage may be held while the core is in reset
    resetStallsLow: assert property (@(posedge clock)
        reset |-> !(idExceptionStall || exExceptionStall || memExceptionStall))
        else $error("Exception stall high during reset");

    // One redirect per cycle at most
    singleTake: assert property (@(posedge clock) disable iff (reset)
        $onehot0({takeNow, eretNow}))
        else $error("Exception and ERET committed in the same cycle");

    // A taken exception sets EXL, so the next cycle runs in kernel mode
    takeEntersKernel: assert property (@(posedge clock) disable iff (reset)
        takeNow |=> kernelMode)
        else $error("Exception taken without entering kernel mode");
endmodule

bind coprocessorZero coprocessorZero_properties u_properties (
    .clock(clock), .reset(reset),
    .idExceptionStall(idExceptionStall), .exExceptionStall(exExceptionStall),
    .memExceptionStall(memExceptionStall), .kernelMode(kernelMode),
    .takeNow(takeBus.take), .eretNow(takeBus.eretCommit)
);

// File: testbench/coprocessorZeroTb.sv
`timescale 1ns/100ps

module coprocessorZeroTb;
    localparam int WORDS_PER_LINE = 8;
    localparam int MAX_LINES      = 64;

    logic clock;
    logic reset;
    logic mfc0, mtc0, eret, ifStall, idStall;
    cp0RegisterPkg::regIndex_t registerIndex;
    cp0RegisterPkg::word_t     writeData;
    logic [4:0] interrupts;
    logic excAdEL, excAdES, excOv, excTr, excSys, excBp, excRi;
    exceptionPkg::address_t idRestartPc, exRestartPc, memRestartPc, badAddrMem;
    logic idIsBd, exIsBd, memIsBd, idIsFlushed, idCanErr, exCanErr, memCanErr;
    cp0RegisterPkg::word_t  readData;
    logic kernelMode, idExceptionStall, exExceptionStall, memExceptionStall;
    logic ifExceptionFlush, idExceptionFlush, exExceptionFlush, memExceptionFlush;
    logic excPcSelect;
    exceptionPkg::address_t excPcOut;
    cp0RegisterPkg::interruptMask_t pendingInterrupts;

    logic [31:0] vectors [0:WORDS_PER_LINE*MAX_LINES-1];
    int lineCount;
    int cycleCount;
    int cycleLimit;

    coprocessorZero u_coprocessorZero (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock; // 40 ns period
    end

    // Run limit covers reset, every vector line and some slack
    always @(posedge clock) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout after %0d cycles, vectors did not finish", cycleCount);
            $display("Test failed");
            $fatal(1);
        end
    end

    // Quiet pipeline with no instruction and no fault
    task automatic idleInputs();
        {mfc0, mtc0, eret, ifStall, idStall} = 5'b0;
        {excAdEL, excAdES, excOv, excTr, excSys, excBp, excRi} = 7'b0;
        {idIsBd, exIsBd, memIsBd, idIsFlushed} = 4'b0;
        {idCanErr, exCanErr, memCanErr} = 3'b0;
        interrupts    = '0;
        registerIndex = '0;
        writeData     = '0;
        idRestartPc   = '0;
        exRestartPc   = '0;
        memRestartPc  = '0;
        badAddrMem    = '0;
    endtask

    task automatic applyLine(input int line);
        logic [31:0] ctrl;
        logic [31:0] pc;
        ctrl = vectors[line*WORDS_PER_LINE];
        pc   = vectors[line*WORDS_PER_LINE+3];
        mfc0 = ctrl[0];
        mtc0 = ctrl[1];
        eret = ctrl[2];
        ifStall = ctrl[3];
        idStall = ctrl[4];
        excAdEL = ctrl[5];
        excAdES = ctrl[6];
        excOv   = ctrl[7];
        excTr   = ctrl[8];
        excSys  = ctrl[9];
        excBp   = ctrl[10];
        excRi   = ctrl[11];
        idIsBd  = ctrl[12];
        exIsBd  = ctrl[13];
        memIsBd = ctrl[14];
        idIsFlushed = ctrl[15];
        idCanErr    = ctrl[16];
        exCanErr    = ctrl[17];
        memCanErr   = ctrl[18];
        interrupts  = ctrl[23:19];
        registerIndex = vectors[line*WORDS_PER_LINE+1][4:0];
        writeData     = vectors[line*WORDS_PER_LINE+2];
        memRestartPc  = pc;          // Oldest instruction
        exRestartPc   = pc + 32'd4;
        idRestartPc   = pc + 32'd8;
        badAddrMem    = pc + 32'd1;  // Misaligned data address
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic checkLine(input int line);
        logic [31:0] flags;
        logic [31:0] mask;
        flags = vectors[line*WORDS_PER_LINE+4];
        mask  = vectors[line*WORDS_PER_LINE+5];
        if (mask[0]) checkValue("kernelMode", 32'(kernelMode), 32'(flags[0]));
        if (mask[1]) checkValue("idExceptionStall", 32'(idExceptionStall), 32'(flags[1]));
        if (mask[2]) checkValue("exExceptionStall", 32'(exExceptionStall), 32'(flags[2]));
        if (mask[3]) checkValue("memExceptionStall", 32'(memExceptionStall), 32'(flags[3]));
        if (mask[4]) checkValue("ifExceptionFlush", 32'(ifExceptionFlush), 32'(flags[4]));
        if (mask[5]) checkValue("idExceptionFlush", 32'(idExceptionFlush), 32'(flags[5]));
        if (mask[6]) checkValue("exExceptionFlush", 32'(exExceptionFlush), 32'(flags[6]));
        if (mask[7]) checkValue("memExceptionFlush", 32'(memExceptionFlush), 32'(flags[7]));
        if (mask[8]) checkValue("excPcSelect", 32'(excPcSelect), 32'(flags[8]));
        // Hardware and software lines stay idle, only the timer can be pending
        if (mask[9]) checkValue("pendingInterrupts", 32'(pendingInterrupts),
                                {24'h000000, flags[9], 7'h00});
        if (mask[16]) checkValue("readData", readData, vectors[line*WORDS_PER_LINE+6]);
        if (mask[17]) checkValue("excPcOut", excPcOut, vectors[line*WORDS_PER_LINE+7]);
    endtask

    initial begin
        cycleCount = 0;
        cycleLimit = 1000;  // Until the vectors are counted
        reset = 1'b1;
        idleInputs();
        $readmemh("testbench/cp0_input.txt", vectors);
        lineCount = 0;
        while (lineCount < MAX_LINES - 1 && vectors[lineCount*WORDS_PER_LINE] !== 32'hFFFF_FFFF)
            lineCount = lineCount + 1;
        cycleLimit = 10 + lineCount + 20;
        repeat (10) @(posedge clock);
        #2 reset = 1'b0;
        for (int i = 0; i < lineCount; i++) begin
            if (i > 0) begin
                @(posedge clock);
                #2;
            end
            applyLine(i);
            #36;  // Just ahead of the next rising edge
            checkLine(i);
        end
        $display("Test passed");
        $finish;
    end
endmodule

// File: testbench/cp0_input.txt
// ctrl index wdata pc | flags flagMask(bit16 read, bit17 pc) readData excPcOut
// ctrl: 0 mfc0 1 mtc0 2 eret 5 AdEL 7 Ov 9 Sys 18 memCanErr; flags: 0 kernel 1-3 stalls 4-7 flushes 8 pcSel 9 ip7
00000000 00 00000000 00000000 00000011 000003FF 00000000 00000000
00000002 0B 00001000 00000000 00000201 000003FF 00000000 00000000
00000002 0E 12345678 00000000 00000001 000003FF 00000000 00000000
00000002 0C 00008000 00000000 00000001 000003FF 00000000 00000000
00000001 0B 00000000 00000000 00000001 000103FF 00001000 00000000
00000001 0E 00000000 00000000 00000001 000103FF 12345678 00000000
00000001 0C 00000000 00000000 00000001 000103FF 00008000 00000000
000000A0 00 00000000 00400100 000001F1 000203FF 00000000 80000180
00000001 0D 00000000 00000000 00000001 000103FF 00000010 00000000
00000001 0E 00000000 00000000 00000001 000103FF 00400100 00000000
00000001 08 00000000 00000000 00000001 000103FF 00400101 00000000
00000004 00 00000000 00000000 00000111 000203FF 00000000 00400100
00000001 0C 00000000 00000000 00000001 000103FF 00008000 00000000
00040200 00 00000000 00400200 00000033 000003FF 00000000 00000000
00040200 00 00000000 00400200 00000033 000003FF 00000000 00000000
00000200 00 00000000 00400200 00000131 000203FF 00000000 80000180
00000001 0D 00000000 00000000 00000001 000103FF 00000020 00000000
00000001 0E 00000000 00000000 00000001 000103FF 00400208 00000000
00000002 0C 00008001 00000000 00000001 000003FF 00000000 00000000
00000002 0B 00000016 00000000 00000001 000003FF 00000000 00000000
00000000 00 00000000 00000000 00000001 000003FF 00000000 00000000
00000000 00 00000000 00000000 00000001 000003FF 00000000 00000000
00000000 00 00000000 00000000 00000001 000003FF 00000000 00000000
00000000 00 00000000 00400300 00000331 000203FF 00000000 80000180
00000001 0D 00000000 00000000 00000201 000103FF 00008000 00000000
00000002 0C 00008010 00000000 00000201 000003FF 00000000 00000000
00000001 0D 00000000 00000000 00000330 000303FF 00000000 80000180
00000001 0D 00000000 00000000 00000201 000103FF 0000802C 00000000
FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF

// File: list.f
+incdir+source
source/cp0RegisterPkg.sv
source/exceptionPkg.sv
source/cp0Interfaces.sv
source/exceptionDecode.sv
source/cp0RegisterExecute.sv
source/cp0ReadResult.sv
source/coprocessorZero.sv
testbench/coprocessorZero_properties.sv
testbench/coprocessorZeroTb.sv

// File: run.sh
#!/bin/sh
# Build and run the CP0 testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module coprocessorZeroTb -f list.f
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/VcoprocessorZeroTb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0
